//--- hybridPkg.sv
package hybridPkg;

    // Decimation and window geometry
    localparam int BITS_PER_FRAME = 4;
    localparam int PHASE_WIDTH = $clog2(BITS_PER_FRAME);
    localparam int WINDOW_FRAMES = 4;
    localparam int WINDOW_BITS = WINDOW_FRAMES * BITS_PER_FRAME;

    // Fill and output timing
    localparam int FILL_FRAMES = 4;
    localparam int FRAME_CNT_WIDTH = $clog2(FILL_FRAMES + 1);
    localparam int OUT_LATENCY = 3;

    localparam logic [PHASE_WIDTH-1:0] LAST_PHASE = PHASE_WIDTH'(BITS_PER_FRAME - 1);
    localparam logic [FRAME_CNT_WIDTH-1:0] FILL_COUNT = FRAME_CNT_WIDTH'(FILL_FRAMES);
    localparam logic [FRAME_CNT_WIDTH-1:0] LAST_FILL = FRAME_CNT_WIDTH'(FILL_FRAMES - 1);

    // Q0.15 coefficients, state in 8.15 plus sign
    localparam int COEF_WIDTH = 16;
    localparam int COEF_FRAC = 15;
    localparam int STATE_WIDTH = 24;
    localparam int PROD_WIDTH = STATE_WIDTH + COEF_WIDTH;
    localparam int SUM_WIDTH = STATE_WIDTH + 1;

    // Output format
    localparam int OUT_WIDTH = 14;
    localparam int OUT_SHIFT = 2;
    localparam logic signed [OUT_WIDTH-1:0] OUT_MAX = {1'b0, {(OUT_WIDTH - 1){1'b1}}};
    localparam logic signed [OUT_WIDTH-1:0] OUT_MIN = {1'b1, {(OUT_WIDTH - 1){1'b0}}};
    localparam logic [OUT_WIDTH-1:0] OUT_MID = {1'b1, {(OUT_WIDTH - 1){1'b0}}};

    // Lookahead FIR taps, index 0 weights the newest bit
    localparam logic signed [COEF_WIDTH-1:0] HB_COEF [WINDOW_BITS] = '{
        16'sd2400, 16'sd2200, 16'sd2000, 16'sd1800,
        16'sd1600, 16'sd1400, 16'sd1200, 16'sd1000,
        16'sd900,  16'sd800,  16'sd700,  16'sd600,
        16'sd500,  16'sd400,  16'sd300,  16'sd200
    };

    // Leaving frame into the recursion
    localparam logic signed [COEF_WIDTH-1:0] FF_RE [BITS_PER_FRAME] = '{
        16'sd3000, 16'sd2600, 16'sd2200, 16'sd1800
    };
    localparam logic signed [COEF_WIDTH-1:0] FF_IM [BITS_PER_FRAME] = '{
        -16'sd1200, -16'sd800, -16'sd400, 16'sd0
    };

    // Pole per frame, magnitude about 0.67
    localparam logic signed [COEF_WIDTH-1:0] POLE_RE = 16'sd19661;
    localparam logic signed [COEF_WIDTH-1:0] POLE_IM = 16'sd9830;

    // Output weight of the lookback branch
    localparam logic signed [COEF_WIDTH-1:0] WEIGHT_RE = 16'sd29491;
    localparam logic signed [COEF_WIDTH-1:0] WEIGHT_IM = 16'sd3277;

    // Control state
    typedef enum logic {
        FILLING = 1'b0,
        RUNNING = 1'b1
    } ctrlState_t;

endpackage

//--- conversionControl.sv
`timescale 1ns/1ps

module conversionControl (
    input  logic clkDS,
    input  logic rst,
    input  logic bitStrobe,
    output logic frameTick,
    output logic outStrobe,
    output logic outValid
);

    logic [hybridPkg::PHASE_WIDTH-1:0] bitPhase;
    logic [hybridPkg::FRAME_CNT_WIDTH-1:0] frameCount;
    logic [hybridPkg::OUT_LATENCY-1:0] tickDelay;
    hybridPkg::ctrlState_t state;
    logic lastBit;

    // Fourth bit of a frame is being captured
    assign lastBit = bitStrobe && (bitPhase == hybridPkg::LAST_PHASE);

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            bitPhase <= '0;
            frameTick <= 1'b0;
        end else begin
            frameTick <= lastBit;
            if (lastBit) begin
                bitPhase <= '0;
            end else if (bitStrobe) begin
                bitPhase <= bitPhase + 1'b1;
            end
        end
    end

    // Frame count saturates once the window is full
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            frameCount <= '0;
            state <= hybridPkg::FILLING;
        end else begin
            if (lastBit && (frameCount != hybridPkg::FILL_COUNT)) begin
                frameCount <= frameCount + 1'b1;
            end
            case (state)
                hybridPkg::FILLING: begin
                    if (lastBit && (frameCount == hybridPkg::LAST_FILL)) begin
                        state <= hybridPkg::RUNNING;
                    end
                end
                hybridPkg::RUNNING: begin
                    state <= hybridPkg::RUNNING;
                end
                default: begin
                    state <= hybridPkg::FILLING;
                end
            endcase
        end
    end

    // Tick follows the datapath, only frames counted while running get a strobe
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            tickDelay <= '0;
            outValid <= 1'b0;
        end else begin
            tickDelay <= {tickDelay[hybridPkg::OUT_LATENCY-2:0],
                          frameTick && (state == hybridPkg::RUNNING)};
            if (tickDelay[hybridPkg::OUT_LATENCY-2]) begin
                outValid <= 1'b1;
            end
        end
    end

    assign outStrobe = tickDelay[hybridPkg::OUT_LATENCY-1];

endmodule

//--- sampleWindow.sv
`timescale 1ns/1ps

module sampleWindow (
    input  logic clkDS,
    input  logic rst,
    input  logic bitIn,
    input  logic bitStrobe,
    output logic [hybridPkg::WINDOW_BITS-1:0] windowBits,
    output logic [hybridPkg::BITS_PER_FRAME-1:0] leavingFrame
);

    // Newest bit enters at index 0
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            windowBits <= '0;
        end else if (bitStrobe) begin
            windowBits <= {windowBits[hybridPkg::WINDOW_BITS-2:0], bitIn};
        end
    end

    // Collects the bits pushed out of the top of the window
    // After a full frame of strobes it holds exactly the evicted frame,
    // with bit 0 being the most recently evicted one
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            leavingFrame <= '0;
        end else if (bitStrobe) begin
            leavingFrame <= {leavingFrame[hybridPkg::BITS_PER_FRAME-2:0],
                             windowBits[hybridPkg::WINDOW_BITS-1]};
        end
    end

endmodule

//--- lookaheadFir.sv
`timescale 1ns/1ps

module lookaheadFir (
    input  logic clkDS,
    input  logic rst,
    input  logic [hybridPkg::WINDOW_BITS-1:0] windowBits,
    input  logic frameTick,
    output logic signed [hybridPkg::STATE_WIDTH-1:0] aheadSum
);

    logic signed [hybridPkg::STATE_WIDTH-1:0] node [hybridPkg::WINDOW_BITS];
    logic signed [hybridPkg::STATE_WIDTH-1:0] treeSum;

    // Leaves are +coef for a one and -coef for a zero,
    // then pairwise reduction into node[0]
    always_comb begin
        for (int i = 0; i < hybridPkg::WINDOW_BITS; i++) begin
            node[i] = hybridPkg::HB_COEF[i];
            if (!windowBits[i]) begin
                node[i] = -node[i];
            end
        end
        for (int span = 1; span < hybridPkg::WINDOW_BITS; span = span * 2) begin
            for (int i = 0; i < hybridPkg::WINDOW_BITS; i = i + 2 * span) begin
                node[i] = node[i] + node[i+span];
            end
        end
        treeSum = node[0];
    end

    // Quiet between frames
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            aheadSum <= '0;
        end else if (frameTick) begin
            aheadSum <= treeSum;
        end
    end

endmodule

//--- lookbackRecursion.sv
`timescale 1ns/1ps

module lookbackRecursion (
    input  logic clkDS,
    input  logic rst,
    input  logic [hybridPkg::BITS_PER_FRAME-1:0] leavingFrame,
    input  logic frameTick,
    output logic signed [hybridPkg::STATE_WIDTH-1:0] backReal,
    output logic backReady
);

    logic signed [hybridPkg::STATE_WIDTH-1:0] inRe;
    logic signed [hybridPkg::STATE_WIDTH-1:0] inIm;
    logic signed [hybridPkg::STATE_WIDTH-1:0] stateRe;
    logic signed [hybridPkg::STATE_WIDTH-1:0] stateIm;
    logic signed [hybridPkg::STATE_WIDTH-1:0] nextRe;
    logic signed [hybridPkg::STATE_WIDTH-1:0] nextIm;
    logic signed [hybridPkg::STATE_WIDTH-1:0] weightedRe;
    logic signed [hybridPkg::PROD_WIDTH-1:0] poleRr;
    logic signed [hybridPkg::PROD_WIDTH-1:0] poleIi;
    logic signed [hybridPkg::PROD_WIDTH-1:0] poleRi;
    logic signed [hybridPkg::PROD_WIDTH-1:0] poleIr;
    logic signed [hybridPkg::PROD_WIDTH-1:0] weightRr;
    logic signed [hybridPkg::PROD_WIDTH-1:0] weightIi;
    logic stateFresh;

    // Input contribution of the evicted frame
    always_comb begin
        inRe = '0;
        inIm = '0;
        for (int j = 0; j < hybridPkg::BITS_PER_FRAME; j++) begin
            if (leavingFrame[j]) begin
                inRe = inRe + hybridPkg::FF_RE[j];
                inIm = inIm + hybridPkg::FF_IM[j];
            end else begin
                inRe = inRe - hybridPkg::FF_RE[j];
                inIm = inIm - hybridPkg::FF_IM[j];
            end
        end
    end

    // Pole times state, real and imaginary cross terms
    assign poleRr = stateRe * hybridPkg::POLE_RE;
    assign poleIi = stateIm * hybridPkg::POLE_IM;
    assign poleRi = stateIm * hybridPkg::POLE_RE;
    assign poleIr = stateRe * hybridPkg::POLE_IM;

    // Slicing above COEF_FRAC is the arithmetic shift back to 8.15
    assign nextRe = $signed(poleRr[hybridPkg::COEF_FRAC +: hybridPkg::STATE_WIDTH])
                  - $signed(poleIi[hybridPkg::COEF_FRAC +: hybridPkg::STATE_WIDTH])
                  + inRe;
    assign nextIm = $signed(poleRi[hybridPkg::COEF_FRAC +: hybridPkg::STATE_WIDTH])
                  + $signed(poleIr[hybridPkg::COEF_FRAC +: hybridPkg::STATE_WIDTH])
                  + inIm;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            stateRe <= '0;
            stateIm <= '0;
            stateFresh <= 1'b0;
            backReady <= 1'b0;
        end else begin
            stateFresh <= frameTick;
            backReady <= stateFresh;
            if (frameTick) begin
                stateRe <= nextRe;
                stateIm <= nextIm;
            end
        end
    end

    // Only the real part of the weighted state is needed
    assign weightRr = stateRe * hybridPkg::WEIGHT_RE;
    assign weightIi = stateIm * hybridPkg::WEIGHT_IM;
    assign weightedRe = $signed(weightRr[hybridPkg::COEF_FRAC +: hybridPkg::STATE_WIDTH])
                      - $signed(weightIi[hybridPkg::COEF_FRAC +: hybridPkg::STATE_WIDTH]);

    always_ff @(posedge clkDS) begin
        if (stateFresh) begin
            backReal <= weightedRe;
        end
    end

endmodule

//--- resultCombiner.sv
`timescale 1ns/1ps

module resultCombiner (
    input  logic clkDS,
    input  logic rst,
    input  logic signed [hybridPkg::STATE_WIDTH-1:0] aheadSum,
    input  logic frameTick,
    input  logic signed [hybridPkg::STATE_WIDTH-1:0] backReal,
    input  logic backReady,
    output logic [hybridPkg::OUT_WIDTH-1:0] out
);

    logic tickDly;
    logic signed [hybridPkg::STATE_WIDTH-1:0] aheadAligned;
    logic signed [hybridPkg::SUM_WIDTH-1:0] sumFull;
    logic signed [hybridPkg::SUM_WIDTH-1:0] sumScaled;
    logic signed [hybridPkg::OUT_WIDTH-1:0] satValue;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            tickDly <= 1'b0;
        end else begin
            tickDly <= frameTick;
        end
    end

    // One extra stage so the lookahead sum lines up with backReal
    always_ff @(posedge clkDS) begin
        if (tickDly) begin
            aheadAligned <= aheadSum;
        end
    end

    assign sumFull = aheadAligned + backReal;
    assign sumScaled = sumFull >>> hybridPkg::OUT_SHIFT;

    // Clamp to the signed output range
    always_comb begin
        if (sumScaled > hybridPkg::OUT_MAX) begin
            satValue = hybridPkg::OUT_MAX;
        end else if (sumScaled < hybridPkg::OUT_MIN) begin
            satValue = hybridPkg::OUT_MIN;
        end else begin
            satValue = sumScaled[hybridPkg::OUT_WIDTH-1:0];
        end
    end

    // Offset binary by flipping the sign bit
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            out <= hybridPkg::OUT_MID;
        end else if (backReady) begin
            out <= {~satValue[hybridPkg::OUT_WIDTH-1], satValue[hybridPkg::OUT_WIDTH-2:0]};
        end
    end

endmodule

//--- hybridConverterTop.sv
`timescale 1ns/1ps

module hybridConverterTop (
    input  logic clkDS,
    input  logic rst,
    input  logic bitIn,
    input  logic bitStrobe,
    output logic [hybridPkg::OUT_WIDTH-1:0] out,
    output logic outStrobe,
    output logic outValid
);

    logic frameTick;
    logic [hybridPkg::WINDOW_BITS-1:0] windowBits;
    logic [hybridPkg::BITS_PER_FRAME-1:0] leavingFrame;
    logic signed [hybridPkg::STATE_WIDTH-1:0] aheadSum;
    logic signed [hybridPkg::STATE_WIDTH-1:0] backReal;
    logic backReady;

    conversionControl u_conversionControl (
        .clkDS     (clkDS),
        .rst       (rst),
        .bitStrobe (bitStrobe),
        .frameTick (frameTick),
        .outStrobe (outStrobe),
        .outValid  (outValid)
    );

    sampleWindow u_sampleWindow (
        .clkDS        (clkDS),
        .rst          (rst),
        .bitIn        (bitIn),
        .bitStrobe    (bitStrobe),
        .windowBits   (windowBits),
        .leavingFrame (leavingFrame)
    );

    lookaheadFir u_lookaheadFir (
        .clkDS      (clkDS),
        .rst        (rst),
        .windowBits (windowBits),
        .frameTick  (frameTick),
        .aheadSum   (aheadSum)
    );

    lookbackRecursion u_lookbackRecursion (
        .clkDS        (clkDS),
        .rst          (rst),
        .leavingFrame (leavingFrame),
        .frameTick    (frameTick),
        .backReal     (backReal),
        .backReady    (backReady)
    );

    resultCombiner u_resultCombiner (
        .clkDS     (clkDS),
        .rst       (rst),
        .aheadSum  (aheadSum),
        .frameTick (frameTick),
        .backReal  (backReal),
        .backReady (backReady),
        .out       (out)
    );

endmodule

//--- tbHybridConverter.sv
`timescale 1ns/1ps

module tbHybridConverter;

    localparam int STEP_BITS = 80;
    localparam int RUN_BITS = 120;
    localparam int ALT_BITS = 64;
    localparam int RAND_BITS = 200;
    localparam int MAX_GAP = 3;
    localparam int LATENCY = 3;
    localparam int HIST_BITS = hybridPkg::WINDOW_BITS + hybridPkg::BITS_PER_FRAME;
    localparam longint OUT_HI = (64'sd1 <<< (hybridPkg::OUT_WIDTH - 1)) - 1;
    localparam longint OUT_LO = -(64'sd1 <<< (hybridPkg::OUT_WIDTH - 1));
    localparam logic [hybridPkg::OUT_WIDTH-1:0] MID_SCALE = 14'h2000;
    localparam logic [hybridPkg::OUT_WIDTH-1:0] CODE_TOP = 14'h3FFF;
    localparam logic [hybridPkg::OUT_WIDTH-1:0] CODE_BOTTOM = 14'h0000;
    // Bit cycles of all tests at worst-case gaps, plus resets and pipeline drains
    localparam int TEST_CYCLES = 22 + 2 * STEP_BITS + ALT_BITS + 2 * RUN_BITS + RAND_BITS
                               + RAND_BITS * (MAX_GAP + 1) + 50 + 4 * 3 + 10 * 6;
    localparam int CYCLE_LIMIT = TEST_CYCLES + TEST_CYCLES / 4;

    logic clkDS = 1'b0;
    logic rst;
    logic bitIn;
    logic bitStrobe;
    logic [hybridPkg::OUT_WIDTH-1:0] out;
    logic outStrobe;
    logic outValid;

    // Reference model
    logic [HIST_BITS-1:0] hist;
    longint stRe;
    longint stIm;
    int phase;
    int frameNum;
    logic [hybridPkg::OUT_WIDTH-1:0] expOut [$];
    int expCycle [$];
    logic expValid;

    int cycleCount = 0;
    int strobeCount = 0;
    int errorCount = 0;
    int passCount = 0;
    int failCount = 0;
    logic checking = 1'b0;
    integer seed;
    logic [31:0] rnd;
    logic [hybridPkg::OUT_WIDTH-1:0] observed [$];
    logic [hybridPkg::OUT_WIDTH-1:0] refOuts [$];
    logic randBits [RAND_BITS];
    logic [hybridPkg::OUT_WIDTH-1:0] wantOut;
    int wantCycle;

    hybridConverterTop u_hybridConverterTop (
        .clkDS     (clkDS),
        .rst       (rst),
        .bitIn     (bitIn),
        .bitStrobe (bitStrobe),
        .out       (out),
        .outStrobe (outStrobe),
        .outValid  (outValid)
    );

    always #50 clkDS = ~clkDS;

    // Scale, saturate and flip the sign bit
    function automatic logic [hybridPkg::OUT_WIDTH-1:0] toOffsetBinary(input longint sum);
        longint scaled;
        logic [hybridPkg::OUT_WIDTH-1:0] code;
        begin
            scaled = sum >>> hybridPkg::OUT_SHIFT;
            if (scaled > OUT_HI) begin
                scaled = OUT_HI;
            end else if (scaled < OUT_LO) begin
                scaled = OUT_LO;
            end
            code = scaled[hybridPkg::OUT_WIDTH-1:0];
            code[hybridPkg::OUT_WIDTH-1] = ~code[hybridPkg::OUT_WIDTH-1];
            return code;
        end
    endfunction

    task clearModel;
        begin
            hist = '0;
            stRe = 0;
            stIm = 0;
            phase = 0;
            frameNum = 0;
            expOut.delete();
            expCycle.delete();
            expValid = 1'b0;
        end
    endtask

    // hist[15:0] is the window, hist[19:16] the frame that just left it
    task modelBit(input logic b);
        longint ahead;
        longint inRe;
        longint inIm;
        longint nRe;
        longint nIm;
        longint back;
        begin
            hist = {hist[HIST_BITS-2:0], b};
            phase = phase + 1;
            if (phase == hybridPkg::BITS_PER_FRAME) begin
                phase = 0;
                frameNum = frameNum + 1;
                ahead = 0;
                for (int i = 0; i < hybridPkg::WINDOW_BITS; i++) begin
                    ahead += hist[i] ? longint'(hybridPkg::HB_COEF[i])
                                     : -longint'(hybridPkg::HB_COEF[i]);
                end
                inRe = 0;
                inIm = 0;
                for (int j = 0; j < hybridPkg::BITS_PER_FRAME; j++) begin
                    inRe += hist[hybridPkg::WINDOW_BITS+j] ? longint'(hybridPkg::FF_RE[j])
                                                           : -longint'(hybridPkg::FF_RE[j]);
                    inIm += hist[hybridPkg::WINDOW_BITS+j] ? longint'(hybridPkg::FF_IM[j])
                                                           : -longint'(hybridPkg::FF_IM[j]);
                end
                nRe = ((stRe * longint'(hybridPkg::POLE_RE)) >>> hybridPkg::COEF_FRAC)
                    - ((stIm * longint'(hybridPkg::POLE_IM)) >>> hybridPkg::COEF_FRAC) + inRe;
                nIm = ((stIm * longint'(hybridPkg::POLE_RE)) >>> hybridPkg::COEF_FRAC)
                    + ((stRe * longint'(hybridPkg::POLE_IM)) >>> hybridPkg::COEF_FRAC) + inIm;
                stRe = nRe;
                stIm = nIm;
                back = ((nRe * longint'(hybridPkg::WEIGHT_RE)) >>> hybridPkg::COEF_FRAC)
                     - ((nIm * longint'(hybridPkg::WEIGHT_IM)) >>> hybridPkg::COEF_FRAC);
                if (frameNum >= hybridPkg::FILL_FRAMES) begin
                    expOut.push_back(toOffsetBinary(ahead + back));
                    // Capturing edge is the next rising edge
                    expCycle.push_back(cycleCount + 1);
                end
            end
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task sendBit(input logic b, input int gap);
        begin
            bitIn = b;
            bitStrobe = 1'b1;
            modelBit(b);
            @(negedge clkDS);
            bitStrobe = 1'b0;
            repeat (gap) @(negedge clkDS);
        end
    endtask

    task applyReset;
        begin
            rst = 1'b0;
            checking = 1'b1;
            clearModel();
            repeat (2) @(posedge clkDS);
            assert (out == MID_SCALE) else begin
                $display("error out expected 0x%h got 0x%h", MID_SCALE, out);
                errorCount++;
            end
            assert (outStrobe == 1'b0 && outValid == 1'b0) else begin
                $display("outStrobe or outValid is high while reset is held");
                errorCount++;
            end
            @(negedge clkDS);
            rst = 1'b1;
        end
    endtask

    task waitDrain;
        begin
            while (expOut.size() != 0) @(negedge clkDS);
        end
    endtask

    task checkCount(input int expected, input int got);
        begin
            assert (expected == got) else begin
                $display("error strobe count expected 0x%h got 0x%h", expected, got);
                errorCount++;
            end
        end
    endtask

    task finishTest(input string name, input int startErrors);
        begin
            if (errorCount == startErrors) begin
                passCount++;
                $display("%s: ok", name);
            end else begin
                failCount++;
                $display("%s: %0d errors", name, errorCount - startErrors);
            end
        end
    endtask

    task resetAndFill;
        int startErrors;
        int startStrobes;
        begin
            startErrors = errorCount;
            applyReset();
            startStrobes = strobeCount;
            for (int i = 0; i < 3 * hybridPkg::BITS_PER_FRAME; i++) begin
                sendBit(i[0], 0);
            end
            repeat (6) @(negedge clkDS);
            checkCount(0, strobeCount - startStrobes);
            assert (outValid == 1'b0) else begin
                $display("error outValid expected 0x0 got 0x%h", outValid);
                errorCount++;
            end
            for (int i = 0; i < hybridPkg::BITS_PER_FRAME; i++) begin
                sendBit(1'b1, 0);
            end
            waitDrain();
            checkCount(1, strobeCount - startStrobes);
            assert (outValid == 1'b1) else begin
                $display("error outValid expected 0x1 got 0x%h", outValid);
                errorCount++;
            end
            finishTest("reset and fill", startErrors);
        end
    endtask

    task constantStreams;
        int startErrors;
        logic [hybridPkg::OUT_WIDTH-1:0] settled;
        begin
            startErrors = errorCount;
            for (int k = 0; k < 2; k++) begin
                observed.delete();
                settled = (k == 0) ? CODE_TOP : CODE_BOTTOM;
                for (int i = 0; i < STEP_BITS; i++) begin
                    sendBit(k == 0, 0);
                end
                waitDrain();
                // A long constant stream settles past full scale
                for (int n = observed.size() - 2; n < observed.size(); n++) begin
                    assert (observed[n] == settled) else begin
                        $display("error out expected 0x%h got 0x%h", settled, observed[n]);
                        errorCount++;
                    end
                end
            end
            finishTest("constant streams", startErrors);
        end
    endtask

    task patternAndSaturation;
        int startErrors;
        begin
            startErrors = errorCount;
            for (int i = 0; i < ALT_BITS; i++) begin
                sendBit(i[0], 0);
            end
            for (int i = 0; i < RUN_BITS; i++) begin
                sendBit(1'b1, 0);
            end
            waitDrain();
            assert (observed[$] == CODE_TOP) else begin
                $display("error out expected 0x%h got 0x%h", CODE_TOP, observed[$]);
                errorCount++;
            end
            for (int i = 0; i < RUN_BITS; i++) begin
                sendBit(1'b0, 0);
            end
            waitDrain();
            assert (observed[$] == CODE_BOTTOM) else begin
                $display("error out expected 0x%h got 0x%h", CODE_BOTTOM, observed[$]);
                errorCount++;
            end
            finishTest("pattern and saturation", startErrors);
        end
    endtask

    task randomStream;
        int startErrors;
        begin
            startErrors = errorCount;
            applyReset();
            observed.delete();
            for (int i = 0; i < RAND_BITS; i++) begin
                rnd = $random(seed);
                randBits[i] = rnd[0];
                sendBit(randBits[i], 0);
            end
            waitDrain();
            refOuts = observed;
            finishTest("random stream", startErrors);
        end
    endtask

    task randomGaps;
        int startErrors;
        begin
            startErrors = errorCount;
            applyReset();
            observed.delete();
            for (int i = 0; i < RAND_BITS; i++) begin
                rnd = $random(seed);
                sendBit(randBits[i], rnd % (MAX_GAP + 1));
            end
            waitDrain();
            checkCount(refOuts.size(), observed.size());
            for (int i = 0; i < observed.size() && i < refOuts.size(); i++) begin
                assert (observed[i] == refOuts[i]) else begin
                    $display("error out expected 0x%h got 0x%h", refOuts[i], observed[i]);
                    errorCount++;
                end
            end
            finishTest("random gaps", startErrors);
        end
    endtask

    task midRunReset;
        int startErrors;
        int startStrobes;
        begin
            startErrors = errorCount;
            // Two frames and a half, the second frame is still in the pipeline
            for (int i = 0; i < 10; i++) begin
                sendBit(i < 5, 0);
            end
            applyReset();
            startStrobes = strobeCount;
            for (int i = 0; i < 40; i++) begin
                sendBit(i % 3 == 0, 0);
            end
            waitDrain();
            checkCount(40 / hybridPkg::BITS_PER_FRAME - (hybridPkg::FILL_FRAMES - 1),
                       strobeCount - startStrobes);
            finishTest("reset mid run", startErrors);
        end
    endtask

    // Output monitor on every rising edge
    always @(posedge clkDS) begin
        cycleCount = cycleCount + 1;
        if (checking && rst) begin
            if (outStrobe) begin
                strobeCount++;
                observed.push_back(out);
                assert (expOut.size() != 0) else begin
                    $display("outStrobe pulsed with no output expected");
                    errorCount++;
                end
                if (expOut.size() != 0) begin
                    wantOut = expOut.pop_front();
                    wantCycle = expCycle.pop_front();
                    expValid = 1'b1;
                    assert (out == wantOut) else begin
                        $display("error out expected 0x%h got 0x%h", wantOut, out);
                        errorCount++;
                    end
                    // Registered at E+3, seen at the following edge
                    assert (cycleCount == wantCycle + LATENCY + 1) else begin
                        $display("outStrobe came at cycle %0d instead of cycle %0d",
                                 cycleCount, wantCycle + LATENCY + 1);
                        errorCount++;
                    end
                end
            end
            assert (outValid == expValid) else begin
                $display("error outValid expected 0x%h got 0x%h", expValid, outValid);
                errorCount++;
            end
        end
    end

    initial begin
        while (cycleCount < CYCLE_LIMIT) @(negedge clkDS);
        $display("timeout: simulation did not finish");
        $display("Test failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        bitIn = 1'b0;
        bitStrobe = 1'b0;
        seed = 32'had912a04;
        clearModel();
        @(negedge clkDS);
        resetAndFill();
        constantStreams();
        patternAndSaturation();
        randomStream();
        randomGaps();
        midRunReset();
        $display("Summary: %0d tests ok, %0d tests with errors", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- hybridConverterTop.f
hybridPkg.sv
conversionControl.sv
sampleWindow.sv
lookaheadFir.sv
lookbackRecursion.sv
resultCombiner.sv
hybridConverterTop.sv
tbHybridConverter.sv
